// ==== Bender.yml ====
package:
  name: rdma_recv_path

sources:
  - files:
      - rdmaPkg.sv
      - packetFifo.sv
      - cutControl.sv
      - payloadCounter.sv
      - payloadAligner.sv
      - rdmaRecvPath.sv
  - target: test
    files:
      - tbRdmaRecvPath.sv

// ==== cutControl.sv ====
`default_nettype none

module cutControl (
   input  wire logic           clock,
   input  wire logic           reset,
   input  wire logic           headValid,
   input  wire logic           headSop,
   input  wire logic           headEop,
   input  wire rdmaPkg::beat_t headData,
   input  wire logic           lastWord,
   output logic                pop,
   output logic                loadCount,
   output logic                step,
   output logic                shiftEnable,
   output logic                emit,
   output rdmaPkg::wordCount_t payloadLength,
   output logic                hdrValid,
   output rdmaPkg::control_t   hdrControl,
   output rdmaPkg::rdmaHeader_t hdrHeader,
   output rdmaPkg::queueNum_t  hdrQueue,
   output logic                frameError
);

   rdmaPkg::cutState_t state;
   rdmaPkg::cutState_t nextState;
   rdmaPkg::opcode_t   opcode;
   logic               sendPacket;
   logic               endGood;
   logic               endBad;

   // Every state consumes the head beat and DROP just throws it away
   assign pop = headValid;

   assign payloadLength = headData[rdmaPkg::LengthLsb +: $bits(rdmaPkg::wordCount_t)];
   assign opcode        = headData[rdmaPkg::RdmapControlLsb +: $bits(rdmaPkg::opcode_t)];

   assign loadCount   = pop && state == rdmaPkg::IDLE && headSop;
   assign step        = pop && state == rdmaPkg::PAYLOAD;
   assign shiftEnable = pop;
   assign emit        = step && sendPacket;

   always_comb begin
      nextState = state;
      endGood   = 1'b0;
      endBad    = 1'b0;
      if (pop) begin
         case (state)
            rdmaPkg::IDLE, rdmaPkg::PAYLOAD: begin
               if (state == rdmaPkg::IDLE && !headSop) begin
                  // Stray beat outside a packet
                  endBad = 1'b1;
               end else if (headEop) begin
                  endGood   = lastWord;
                  endBad    = !lastWord;
                  nextState = rdmaPkg::IDLE;
               end else if (lastWord) begin
                  // Eop missing so the rest of the packet is skipped
                  endBad    = 1'b1;
                  nextState = rdmaPkg::DROP;
               end else begin
                  nextState = rdmaPkg::PAYLOAD;
               end
            end
            rdmaPkg::DROP: begin
               if (headEop) begin
                  nextState = rdmaPkg::IDLE;
               end
            end
            default: nextState = rdmaPkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         state      <= rdmaPkg::IDLE;
         hdrValid   <= 1'b0;
         frameError <= 1'b0;
         sendPacket <= 1'b0;
      end else begin
         state      <= nextState;
         hdrValid   <= endGood;
         frameError <= endBad;
         if (loadCount) begin
            sendPacket <= opcode == rdmaPkg::SendOpcode;
         end
      end
   end

   // Header fields held from the sop beat until the next packet
   always_ff @(posedge clock) begin
      if (loadCount) begin
         hdrControl <= headData[rdmaPkg::RdmapControlLsb +: $bits(rdmaPkg::control_t)];
         hdrHeader  <= headData[rdmaPkg::RdmaHeaderLsb +: $bits(rdmaPkg::rdmaHeader_t)];
         hdrQueue   <= headData[rdmaPkg::DdpControlLsb +: $bits(rdmaPkg::queueNum_t)];
      end
   end

endmodule

`default_nettype wire

// ==== list.f ====
rdmaPkg.sv
packetFifo.sv
cutControl.sv
payloadCounter.sv
payloadAligner.sv
rdmaRecvPath.sv
tbRdmaRecvPath.sv

// ==== packetFifo.sv ====
`default_nettype none

module packetFifo #(
   parameter int FifoDepth = 8
) (
   input  wire logic           clock,
   input  wire logic           reset,
   input  wire logic           write,
   input  wire logic           writeSop,
   input  wire logic           writeEop,
   input  wire rdmaPkg::beat_t writeData,
   input  wire logic           pop,
   output logic                headValid,
   output logic                headSop,
   output logic                headEop,
   output rdmaPkg::beat_t      headData,
   output logic                full
);

   localparam int PtrBits   = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
   localparam int CountBits = $clog2(FifoDepth + 1);
   localparam int EntryBits = $bits(rdmaPkg::beat_t) + 2;

   logic [EntryBits-1:0] memory [FifoDepth];
   logic [PtrBits-1:0]   readPtr;
   logic [PtrBits-1:0]   writePtr;
   logic [CountBits-1:0] count;
   logic                 doWrite;
   logic                 doRead;

   function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
      if (ptr == PtrBits'(FifoDepth - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign full      = count == CountBits'(FifoDepth);
   assign headValid = count != '0;
   assign doWrite   = write && !full;
   assign doRead    = pop && headValid;

   // Show-ahead head entry
   assign {headSop, headEop, headData} = memory[readPtr];

   always_ff @(posedge clock) begin
      if (doWrite) begin
         memory[writePtr] <= {writeSop, writeEop, writeData};
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         readPtr  <= '0;
         writePtr <= '0;
         count    <= '0;
      end else begin
         if (doWrite) begin
            writePtr <= nextPtr(writePtr);
         end
         if (doRead) begin
            readPtr <= nextPtr(readPtr);
         end
         case ({doWrite, doRead})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== payloadAligner.sv ====
`default_nettype none

module payloadAligner (
   input  wire logic               clock,
   input  wire logic               reset,
   input  wire logic               shiftEnable,
   input  wire logic               emit,
   input  wire rdmaPkg::queueNum_t queue,
   input  wire rdmaPkg::beat_t     data,
   output logic                    push,
   output rdmaPkg::beat_t          pushData,
   output rdmaPkg::queueNum_t      pushQueue
);

   // Low part of the previous beat waiting for its tail
   logic [rdmaPkg::RemainderBits-1:0] remainder;

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         push <= 1'b0;
      end else begin
         push <= emit;
      end
   end

   always_ff @(posedge clock) begin
      if (shiftEnable) begin
         remainder <= data[rdmaPkg::RemainderBits-1:0];
      end
      if (emit) begin
         // Old remainder on top with head bits of this beat below
         pushData  <= {remainder, data[rdmaPkg::BeatBits-1 -: rdmaPkg::HeaderBits]};
         pushQueue <= queue;
      end
   end

endmodule

`default_nettype wire

// ==== payloadCounter.sv ====
`default_nettype none

module payloadCounter (
   input  wire logic                clock,
   input  wire logic                reset,
   input  wire logic                load,
   input  wire logic                step,
   input  wire rdmaPkg::wordCount_t length,
   output logic                     lastWord
);

   // Payload words still owed by the current packet
   rdmaPkg::wordCount_t remaining;

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         remaining <= '0;
      end else if (load) begin
         remaining <= length;
      end else if (step) begin
         remaining <= remaining - 1'b1;
      end
   end

   // The fresh length decides on the sop beat and the count decides later
   assign lastWord = load ? (length == '0)
                          : (remaining == rdmaPkg::wordCount_t'(1));

endmodule

`default_nettype wire

// ==== rdmaPkg.sv ====
`default_nettype none

package rdmaPkg;

   // Beat geometry
   localparam int BeatBits      = 256;
   localparam int HeaderBits    = 80;
   localparam int RemainderBits = BeatBits - HeaderBits;

   typedef logic [BeatBits-1:0] beat_t;
   typedef logic [7:0]          control_t;
   typedef logic [47:0]         rdmaHeader_t;
   typedef logic [3:0]          queueNum_t;
   typedef logic [15:0]         wordCount_t;
   typedef logic [3:0]          opcode_t;

   // Sop beat header fields from the top bit downward are DDP control,
   // RDMAP control, DDP length and RDMAP header
   localparam int DdpControlLsb   = BeatBits - $bits(control_t);
   localparam int RdmapControlLsb = DdpControlLsb - $bits(control_t);
   localparam int LengthLsb       = RdmapControlLsb - $bits(wordCount_t);
   localparam int RdmaHeaderLsb   = LengthLsb - $bits(rdmaHeader_t);

   // RDMAP opcodes
   localparam opcode_t SendOpcode = 4'h1;
   localparam opcode_t ReqOpcode  = 4'h2;
   localparam opcode_t AckOpcode  = 4'h3;

   // Cutter states
   typedef enum logic [1:0] {
      IDLE,
      PAYLOAD,
      DROP
   } cutState_t;

endpackage

`default_nettype wire

// ==== rdmaRecvPath.sv ====
`default_nettype none

module rdmaRecvPath #(
   parameter int FifoDepth = 8
) (
   input  wire logic           clock,
   input  wire logic           reset,
   input  wire logic           beatValid,
   input  wire logic           beatSop,
   input  wire logic           beatEop,
   input  wire rdmaPkg::beat_t beatData,
   output logic                fifoFull,
   output logic                push,
   output rdmaPkg::beat_t      pushData,
   output rdmaPkg::queueNum_t  pushQueue,
   output logic                hdrValid,
   output rdmaPkg::control_t   hdrControl,
   output rdmaPkg::rdmaHeader_t hdrHeader,
   output rdmaPkg::queueNum_t  hdrQueue,
   output logic                frameError
);

   logic                headValid;
   logic                headSop;
   logic                headEop;
   rdmaPkg::beat_t      headData;
   logic                pop;
   logic                loadCount;
   logic                step;
   logic                lastWord;
   logic                shiftEnable;
   logic                emit;
   rdmaPkg::wordCount_t payloadLength;

   packetFifo #(.FifoDepth(FifoDepth)) fifo (
      .clock(clock), .reset(reset),
      .write(beatValid), .writeSop(beatSop), .writeEop(beatEop), .writeData(beatData),
      .pop(pop),
      .headValid(headValid), .headSop(headSop), .headEop(headEop), .headData(headData),
      .full(fifoFull)
   );

   cutControl cutter (
      .clock(clock), .reset(reset),
      .headValid(headValid), .headSop(headSop), .headEop(headEop), .headData(headData),
      .lastWord(lastWord),
      .pop(pop), .loadCount(loadCount), .step(step),
      .shiftEnable(shiftEnable), .emit(emit), .payloadLength(payloadLength),
      .hdrValid(hdrValid), .hdrControl(hdrControl), .hdrHeader(hdrHeader),
      .hdrQueue(hdrQueue), .frameError(frameError)
   );

   payloadCounter counter (
      .clock(clock), .reset(reset),
      .load(loadCount), .step(step), .length(payloadLength),
      .lastWord(lastWord)
   );

   // Queue number is held by the cutter for the whole packet
   payloadAligner aligner (
      .clock(clock), .reset(reset),
      .shiftEnable(shiftEnable), .emit(emit), .queue(hdrQueue), .data(headData),
      .push(push), .pushData(pushData), .pushQueue(pushQueue)
   );

endmodule

`default_nettype wire

// ==== tbRdmaRecvPath.sv ====
`default_nettype none

module tbRdmaRecvPath;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int FifoDepth = 8;
   localparam int WaitLimit = 200;

   logic                 clock;
   logic                 reset;
   logic                 beatValid;
   logic                 beatSop;
   logic                 beatEop;
   rdmaPkg::beat_t       beatData;
   logic                 fifoFull;
   logic                 push;
   rdmaPkg::beat_t       pushData;
   rdmaPkg::queueNum_t   pushQueue;
   logic                 hdrValid;
   rdmaPkg::control_t    hdrControl;
   rdmaPkg::rdmaHeader_t hdrHeader;
   rdmaPkg::queueNum_t   hdrQueue;
   logic                 frameError;

   // Reference model state
   rdmaPkg::beat_t       pushWords [$];
   rdmaPkg::queueNum_t   pushQueues [$];
   bit                   pushLasts [$];
   rdmaPkg::control_t    hdrControls [$];
   rdmaPkg::rdmaHeader_t hdrHeaders [$];
   rdmaPkg::queueNum_t   hdrQueues [$];
   int                   errorsDue;
   int                   occupancy;
   bit                   written;
   logic [15:0]          lfsr;

   // Heads of the expectation queues as seen by the assertions
   bit                   pushDue;
   bit                   hdrDue;
   rdmaPkg::beat_t       expPushData;
   rdmaPkg::queueNum_t   expPushQueue;
   bit                   expPushLast;
   rdmaPkg::control_t    expControl;
   rdmaPkg::rdmaHeader_t expHeader;
   rdmaPkg::queueNum_t   expQueue;

   rdmaRecvPath #(.FifoDepth(FifoDepth)) uut (
      .clock(clock), .reset(reset),
      .beatValid(beatValid), .beatSop(beatSop), .beatEop(beatEop), .beatData(beatData),
      .fifoFull(fifoFull),
      .push(push), .pushData(pushData), .pushQueue(pushQueue),
      .hdrValid(hdrValid), .hdrControl(hdrControl), .hdrHeader(hdrHeader),
      .hdrQueue(hdrQueue), .frameError(frameError)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   task automatic failRun(input string what);
      $display("%s", what);
      $display("Test FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic valueError(input string name, input rdmaPkg::beat_t got,
                             input rdmaPkg::beat_t expected);
      failRun($sformatf("** Error at %0t ns: %s is %h, expected %h",
                        $time, name, got, expected));
   endtask

   // Taps at 16, 14, 13 and 11
   function automatic logic takeBit();
      logic feedback;
      feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], feedback};
      return feedback;
   endfunction

   function automatic rdmaPkg::beat_t takeBits(input int count);
      rdmaPkg::beat_t result;
      result = '0;
      for (int i = 0; i < count; i++) begin
         result = {result[254:0], takeBit()};
      end
      return result;
   endfunction

   function automatic int randomLength();
      return int'(takeBits(3)) % 6 + 1;
   endfunction

   task automatic refreshHeads();
      pushDue = pushWords.size() != 0;
      hdrDue  = hdrControls.size() != 0;
      if (pushDue) begin
         expPushData  = pushWords[0];
         expPushQueue = pushQueues[0];
         expPushLast  = pushLasts[0];
      end
      if (hdrDue) begin
         expControl = hdrControls[0];
         expHeader  = hdrHeaders[0];
         expQueue   = hdrQueues[0];
      end
   endtask

   task automatic writeBeat(input logic sop, input logic eop, input rdmaPkg::beat_t data);
      int waited;
      waited = 0;
      while (fifoFull) begin
         if (waited == WaitLimit) failRun("fifoFull stayed high past the timeout");
         @(posedge clock);
         #1;
         waited++;
      end
      beatValid = 1'b1;
      beatSop   = sop;
      beatEop   = eop;
      beatData  = data;
      written   = 1'b1;
      @(posedge clock);
      #1;
      beatValid = 1'b0;
   endtask

   // An eopShift of -1 ends the packet a beat early and +1 a beat late
   task automatic writePacket(input rdmaPkg::opcode_t op, input int words, input int eopShift);
      rdmaPkg::beat_t       beats [8];
      rdmaPkg::control_t    ddpControl;
      rdmaPkg::control_t    rdmapControl;
      rdmaPkg::rdmaHeader_t header;
      logic [175:0]         lowBits;
      int                   beatCount;
      int                   pushCount;
      ddpControl      = rdmaPkg::control_t'(takeBits(8));
      rdmapControl    = rdmaPkg::control_t'(takeBits(8));
      rdmapControl[3:0] = op;
      header          = rdmaPkg::rdmaHeader_t'(takeBits(48));
      lowBits         = 176'(takeBits(176));
      beatCount       = words + 1 + eopShift;
      beats[0] = {ddpControl, rdmapControl, rdmaPkg::wordCount_t'(words), header, lowBits};
      for (int i = 1; i < beatCount; i++) begin
         beats[i] = takeBits(256);
      end
      pushCount = 0;
      if (op == rdmaPkg::SendOpcode) begin
         pushCount = (eopShift < 0) ? words - 1 : words;
      end
      for (int k = 0; k < pushCount; k++) begin
         pushWords.push_back({beats[k][175:0], beats[k+1][255:176]});
         pushQueues.push_back(ddpControl[3:0]);
         pushLasts.push_back(eopShift == 0 && k == words - 1);
      end
      if (eopShift == 0) begin
         hdrControls.push_back(rdmapControl);
         hdrHeaders.push_back(header);
         hdrQueues.push_back(ddpControl[3:0]);
      end else begin
         errorsDue++;
      end
      refreshHeads();
      for (int i = 0; i < beatCount; i++) begin
         writeBeat(i == 0, i == beatCount - 1, beats[i]);
      end
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) @(posedge clock);
      #1;
   endtask

   // FIFO fill level with one beat leaving per cycle while any is held
   always @(posedge clock or negedge reset) begin
      if (!reset) begin
         occupancy <= 0;
      end else begin
         occupancy <= occupancy + int'(beatValid && occupancy != FifoDepth)
                                - int'(occupancy != 0);
      end
   end

   // Retire expectations once the assertions have seen them
   always @(negedge clock) begin
      if (reset) begin
         if (push && pushDue) begin
            void'(pushWords.pop_front());
            void'(pushQueues.pop_front());
            void'(pushLasts.pop_front());
         end
         if (hdrValid && hdrDue) begin
            void'(hdrControls.pop_front());
            void'(hdrHeaders.pop_front());
            void'(hdrQueues.pop_front());
         end
         if (frameError && errorsDue != 0) begin
            errorsDue--;
         end
         refreshHeads();
      end
   end

   assert property (@(negedge clock) !written |-> !push && !hdrValid && !frameError && !fifoFull)
      else failRun("An output was active before the first beat was written");
   assert property (@(negedge clock) disable iff (!reset)
                    fifoFull == (occupancy == FifoDepth))
      else valueError("fifoFull", $sampled(fifoFull), $sampled(occupancy == FifoDepth));
   assert property (@(negedge clock) disable iff (!reset) push |-> pushDue)
      else failRun("push pulsed with no payload word expected");
   assert property (@(negedge clock) disable iff (!reset)
                    push && pushDue |-> pushData == expPushData)
      else valueError("pushData", $sampled(pushData), $sampled(expPushData));
   assert property (@(negedge clock) disable iff (!reset)
                    push && pushDue |-> pushQueue == expPushQueue)
      else valueError("pushQueue", $sampled(pushQueue), $sampled(expPushQueue));
   assert property (@(negedge clock) disable iff (!reset) hdrValid |-> hdrDue)
      else failRun("hdrValid pulsed with no correct packet expected");
   assert property (@(negedge clock) disable iff (!reset)
                    hdrValid && hdrDue |-> hdrControl == expControl)
      else valueError("hdrControl", $sampled(hdrControl), $sampled(expControl));
   assert property (@(negedge clock) disable iff (!reset)
                    hdrValid && hdrDue |-> hdrHeader == expHeader)
      else valueError("hdrHeader", $sampled(hdrHeader), $sampled(expHeader));
   assert property (@(negedge clock) disable iff (!reset)
                    hdrValid && hdrDue |-> hdrQueue == expQueue)
      else valueError("hdrQueue", $sampled(hdrQueue), $sampled(expQueue));
   assert property (@(negedge clock) disable iff (!reset) frameError |-> errorsDue != 0)
      else failRun("frameError pulsed with no framing error expected");
   // Last word and header pulse leave together
   assert property (@(negedge clock) disable iff (!reset)
                    push && pushDue && expPushLast |-> hdrValid)
      else failRun("Last payload word of a send packet came without its header pulse");

   initial begin
      int waited;
      reset     = 1'b0;
      beatValid = 1'b0;
      beatSop   = 1'b0;
      beatEop   = 1'b0;
      beatData  = '0;
      written   = 1'b0;
      errorsDue = 0;
      lfsr      = 16'd65266;
      refreshHeads();
      repeat (5) @(posedge clock);
      #1;
      reset = 1'b1;
      idle(3);

      repeat (4) writePacket(rdmaPkg::SendOpcode, randomLength(), 0);
      idle(2);
      writePacket(rdmaPkg::ReqOpcode, 0, 0);
      writePacket(rdmaPkg::AckOpcode, 0, 0);
      writePacket(rdmaPkg::ReqOpcode, 2, 0);
      writePacket(rdmaPkg::AckOpcode, 1, 0);
      writePacket(rdmaPkg::SendOpcode, 0, 0);
      idle(2);

      // Framing errors with a good packet after each
      writePacket(rdmaPkg::SendOpcode, randomLength() + 1, -1);
      writePacket(rdmaPkg::SendOpcode, randomLength(), 0);
      writePacket(rdmaPkg::SendOpcode, randomLength(), 1);
      writePacket(rdmaPkg::SendOpcode, randomLength(), 0);
      errorsDue++;
      writeBeat(1'b0, 1'b1, takeBits(256));
      writePacket(rdmaPkg::SendOpcode, randomLength(), 0);

      // Back-to-back burst
      for (int i = 0; i < 8; i++) begin
         writePacket((i % 3 == 0) ? rdmaPkg::ReqOpcode : rdmaPkg::SendOpcode,
                     randomLength(), 0);
      end

      waited = 0;
      while ((pushWords.size() != 0 || hdrControls.size() != 0 || errorsDue != 0)
             && waited < WaitLimit) begin
         @(posedge clock);
         waited++;
      end
      idle(4);
      if (pushWords.size() != 0 || hdrControls.size() != 0 || errorsDue != 0) begin
         failRun("Expected outputs still missing after the drain timeout");
      end else begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

`default_nettype wire
